// ==== logic/cpu_isa_pkg.sv ====
// Instruction set view of the CPU as seen by the interrupt subsystem
// Opcodes, register ids and the bus of CPU signals shared by all stages
package cpu_isa_pkg;

    // CPU data path width, fixed on the bus
    localparam int CPU_WORD_BITS = 16;

    // Upper six bits of the instruction byte
    typedef logic [5:0] opcode_t;

    // Lower two bits, used as interrupt or slot number
    typedef logic [1:0] arg_t;

    // Register select as used by the register file
    typedef logic [3:0] reg_id_t;

    // One CPU data word
    typedef logic [CPU_WORD_BITS-1:0] cpu_word_t;

    // Instruction byte split into its two fields
    typedef struct packed {
        opcode_t opcode;
        arg_t    arg;
    } instr_t;

    // Interrupt related opcodes, argument in the low bits
    localparam opcode_t OPC_SOFTINT     = 6'h0C;
    localparam opcode_t OPC_SETINT      = 6'h0D;
    localparam opcode_t OPC_GETINT      = 6'h0E;
    localparam opcode_t OPC_SETINTSTACK = 6'h0F;
    localparam opcode_t OPC_GETINTSTACK = 6'h10;

    // Return from interrupt is a full byte, outside the opcodes above
    localparam instr_t INST_RETINT = 8'h44;

    // Program counter in the register file
    localparam reg_id_t REG_PC = 4'hF;

    // Everything the CPU presents to the interrupt block each cycle
    typedef struct packed {
        instr_t    instr;
        cpu_word_t work_reg;
        cpu_word_t pc;
        // High on the cycle the CPU commits its state
        logic      cpu_update;
    } cpu_bus_t;

endpackage

// ==== logic/irq_pkg.sv ====
// Types describing interrupt levels, requests and the capture result
// Shared by the capture, context and vector stages
package irq_pkg;

    // Number of request lines, one per priority
    localparam int IRQ_COUNT = 4;

    // One bit per priority, bit 0 is the most urgent
    typedef logic [IRQ_COUNT-1:0] irq_vec_t;

    // Current or target level
    // 0 to 3 are interrupt contexts, 4 is plain program flow
    typedef logic [2:0] level_t;

    localparam level_t LEVEL_NORMAL = 3'd4;

    // Index into the per-level memories and the routine table
    typedef logic [1:0] irq_idx_t;

    // Result of the capture stage, consumed by the context stage
    typedef struct packed {
        // Masked requests held until the next CPU update
        irq_vec_t pending;
        // Current instruction is a softint
        logic     softint;
    } irq_capture_t;

endpackage

// ==== logic/irq_request_capture.sv ====
// Front stage of the interrupt block: merges external lines and softint
// under the mask and keeps each request latched until the CPU updates
module irq_request_capture (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enable,
    // External request lines, bit 0 is priority 0
    input  irq_pkg::irq_vec_t       irq_lines,
    // A zero bit blocks the matching request
    input  irq_pkg::irq_vec_t       irq_mask,
    input  cpu_isa_pkg::cpu_bus_t   cpu,
    output irq_pkg::irq_capture_t   capture
);

    // Softint decode
    logic              is_softint;
    irq_pkg::irq_vec_t soft_req;

    // Merged and masked requests of this cycle
    irq_pkg::irq_vec_t masked_req;

    // Sticky copy of the masked requests
    irq_pkg::irq_vec_t pending;

    assign is_softint = (cpu.instr.opcode == cpu_isa_pkg::OPC_SOFTINT);

    // One-hot request picked by the instruction argument
    always_comb
    begin
        soft_req = '0;
        if (is_softint)
        begin
            soft_req[cpu.instr.arg] = 1'b1;
        end
    end

    assign masked_req = (irq_lines | soft_req) & irq_mask;

    // Latch behavior
    // On update each bit follows the current request
    // Between updates a request only sets its bit, so pulses survive
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            pending <= '0;
        end
        else if (enable)
        begin
            if (cpu.cpu_update)
            begin
                pending <= masked_req;
            end
            else
            begin
                pending <= pending | masked_req;
            end
        end
    end

    // Softint flag goes with the combinational instruction,
    // the context stage needs it for the return address
    always_comb
    begin
        capture.pending = pending;
        capture.softint = is_softint;
    end

endmodule

// ==== logic/irq_context_stack.sv ====
// Context stage: picks the target level, tracks the current one and keeps the
// per-level return addresses and previous levels for entry and retint
module irq_context_stack #(
    parameter int word_size = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  cpu_isa_pkg::cpu_bus_t     cpu,
    input  irq_pkg::irq_capture_t     capture,
    // Highest priority level with a pending request
    output irq_pkg::level_t           target_level,
    // High while a pending request would preempt the current level
    output logic                      irq_entry,
    // High whenever the level is not the normal context
    output logic                      in_irq_context,
    // Word returned to the CPU by retint and the stack instructions
    output cpu_isa_pkg::cpu_word_t    stack_data
);

    // Current level, normal context out of reset
    irq_pkg::level_t level;

    // Return address and interrupted level, indexed by the level entered
    logic [word_size-1:0] addr_mem [4];
    irq_pkg::level_t      level_mem [4];

    // Instruction decode
    logic is_retint;
    logic is_setintstack;
    logic is_getintstack;

    // Indexes into the memories
    irq_pkg::irq_idx_t target_idx;
    irq_pkg::irq_idx_t level_idx;

    // Actions taken on this clock edge
    logic do_entry;
    logic do_retint;
    logic do_stack_wr;

    // Address saved on entry
    logic [word_size-1:0] entry_addr;

    assign is_retint      = (cpu.instr == cpu_isa_pkg::INST_RETINT);
    assign is_setintstack = (cpu.instr.opcode == cpu_isa_pkg::OPC_SETINTSTACK);
    assign is_getintstack = (cpu.instr.opcode == cpu_isa_pkg::OPC_GETINTSTACK);

    // Priority encoder, lowest set bit wins
    always_comb
    begin
        target_level = irq_pkg::LEVEL_NORMAL;
        for (int i = irq_pkg::IRQ_COUNT - 1; i >= 0; i--)
        begin
            if (capture.pending[i])
            begin
                target_level = irq_pkg::level_t'(i);
            end
        end
    end

    // A lower number is more urgent, so this is preemption
    assign irq_entry      = (target_level < level);
    assign in_irq_context = (level != irq_pkg::LEVEL_NORMAL);

    // Only used when the level is 0 to 3
    assign target_idx = target_level[1:0];
    assign level_idx  = level[1:0];

    // Softint resumes after itself, a hardware interrupt at the same pc
    assign entry_addr = capture.softint ? cpu.pc[word_size-1:0] + 1'b1
                                        : cpu.pc[word_size-1:0];

    // Entry has precedence over the instruction in flight
    assign do_entry    = enable & irq_entry & cpu.cpu_update;
    // Retint with no saved context leaves the level alone
    assign do_retint   = enable & ~do_entry & is_retint & cpu.cpu_update
                         & in_irq_context;
    assign do_stack_wr = enable & ~do_entry & is_setintstack;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            level <= irq_pkg::LEVEL_NORMAL;
        end
        else if (do_entry)
        begin
            level <= target_level;
        end
        else if (do_retint)
        begin
            level <= level_mem[level_idx];
        end
    end

    // Context memories, contents only matter once written
    always_ff @(posedge clk)
    begin
        if (do_entry)
        begin
            addr_mem[target_idx]  <= entry_addr;
            level_mem[target_idx] <= level;
        end
        else if (do_stack_wr)
        begin
            // Software can patch a return address
            addr_mem[cpu.instr.arg] <= cpu.work_reg[word_size-1:0];
        end
    end

    // Read side toward the CPU
    always_comb
    begin
        stack_data = '0;
        if (is_retint)
        begin
            if (in_irq_context)
            begin
                stack_data = cpu_isa_pkg::cpu_word_t'(addr_mem[level_idx]);
            end
        end
        else if (is_getintstack)
        begin
            stack_data = cpu_isa_pkg::cpu_word_t'(addr_mem[cpu.instr.arg]);
        end
        else if (is_setintstack)
        begin
            // Echo of the written word
            stack_data = cpu.work_reg;
        end
    end

endmodule

// ==== logic/irq_vector_table.sv ====
// Vector stage: table of routine addresses written by setint, read by getint
// Also builds the single data word and register select returned to the CPU
module irq_vector_table #(
    parameter int word_size = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enable,
    input  cpu_isa_pkg::cpu_bus_t     cpu,
    input  irq_pkg::level_t           target_level,
    input  cpu_isa_pkg::cpu_word_t    stack_data,
    output cpu_isa_pkg::cpu_word_t    data_out,
    output cpu_isa_pkg::reg_id_t      out_reg,
    // Routine to jump to when the pending interrupt is taken
    output cpu_isa_pkg::cpu_word_t    routine_addr
);

    // Routine addresses, one per level
    logic [word_size-1:0] routines [4];

    // Registered getint result
    logic [word_size-1:0] getint_q;

    logic is_setint;
    logic is_getint;
    logic is_retint;
    logic table_wr;

    assign is_setint = (cpu.instr.opcode == cpu_isa_pkg::OPC_SETINT);
    assign is_getint = (cpu.instr.opcode == cpu_isa_pkg::OPC_GETINT);
    assign is_retint = (cpu.instr == cpu_isa_pkg::INST_RETINT);

    assign table_wr = enable & cpu.cpu_update & is_setint;

    // Table write, committed with the CPU update
    always_ff @(posedge clk)
    begin
        if (table_wr)
        begin
            routines[cpu.instr.arg] <= cpu.work_reg[word_size-1:0];
        end
    end

    // Getint read, zero on any other instruction so the OR below is clean
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            getint_q <= '0;
        end
        else if (enable)
        begin
            if (is_getint)
            begin
                getint_q <= routines[cpu.instr.arg];
            end
            else
            begin
                getint_q <= '0;
            end
        end
    end

    // No routine in the normal context
    always_comb
    begin
        routine_addr = '0;
        if (target_level != irq_pkg::LEVEL_NORMAL)
        begin
            routine_addr = cpu_isa_pkg::cpu_word_t'(routines[target_level[1:0]]);
        end
    end

    // Only one source is nonzero for any given instruction
    assign data_out = cpu_isa_pkg::cpu_word_t'(getint_q) | stack_data;

    // Retint loads the saved address into the program counter
    assign out_reg = is_retint ? cpu_isa_pkg::REG_PC : cpu_isa_pkg::reg_id_t'(0);

endmodule

// ==== logic/irq_controller_top.sv ====
// Interrupt subsystem top: capture, context and vector stages in a row
// The CPU drives the bus and the update strobe, results come back on data_out
module irq_controller_top #(
    parameter int word_size = 16
) (
    input  logic                      clk,
    input  logic                      reset,
    // Low freezes every state element
    input  logic                      enable,
    input  irq_pkg::irq_vec_t         irq_lines,
    input  irq_pkg::irq_vec_t         irq_mask,
    input  cpu_isa_pkg::cpu_bus_t     cpu,
    output cpu_isa_pkg::cpu_word_t    data_out,
    output cpu_isa_pkg::reg_id_t      out_reg,
    output cpu_isa_pkg::cpu_word_t    routine_addr,
    output logic                      irq_entry,
    output logic                      in_irq_context
);

    // Memories cannot be wider than the CPU bus words
    if (word_size > cpu_isa_pkg::CPU_WORD_BITS)
    begin : g_width_check
        $error("word_size exceeds the CPU word width");
    end

    // Stage to stage signals
    irq_pkg::irq_capture_t     capture;
    irq_pkg::level_t           target_level;
    cpu_isa_pkg::cpu_word_t    stack_data;

    irq_request_capture i_capture (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .irq_lines (irq_lines),
        .irq_mask  (irq_mask),
        .cpu       (cpu),
        .capture   (capture)
    );

    irq_context_stack #(
        .word_size (word_size)
    ) i_context (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .cpu            (cpu),
        .capture        (capture),
        .target_level   (target_level),
        .irq_entry      (irq_entry),
        .in_irq_context (in_irq_context),
        .stack_data     (stack_data)
    );

    irq_vector_table #(
        .word_size (word_size)
    ) i_vector (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .cpu          (cpu),
        .target_level (target_level),
        .stack_data   (stack_data),
        .data_out     (data_out),
        .out_reg      (out_reg),
        .routine_addr (routine_addr)
    );

endmodule

// ==== verif/irq_controller_tb.sv ====
// Directed testbench for the interrupt subsystem, the testbench plays the CPU
// Inputs change on the falling edge, outputs are checked just before the rising edge
module irq_controller_tb;

    localparam int CYCLE_LIMIT = 600;
    localparam cpu_isa_pkg::instr_t NOP = 8'h00;

    logic                   clk;
    logic                   reset;
    logic                   enable;
    irq_pkg::irq_vec_t      irq_lines;
    irq_pkg::irq_vec_t      irq_mask;
    cpu_isa_pkg::cpu_bus_t  cpu;
    cpu_isa_pkg::cpu_word_t data_out;
    cpu_isa_pkg::reg_id_t   out_reg;
    cpu_isa_pkg::cpu_word_t routine_addr;
    logic                   irq_entry;
    logic                   in_irq_context;

    // Values applied with the next drive_cycle
    logic                   enable_sel;
    irq_pkg::irq_vec_t      mask_sel;

    // Expected routine table and saved addresses
    cpu_isa_pkg::cpu_word_t routine_exp [4];
    cpu_isa_pkg::cpu_word_t saved_pc2;
    cpu_isa_pkg::cpu_word_t pc_val;
    cpu_isa_pkg::cpu_word_t word_val;

    int    errors;
    int    cycle_count;
    string test_name;

    irq_controller_top #(.word_size(16)) i_dut (
        .clk            (clk),
        .reset          (reset),
        .enable         (enable),
        .irq_lines      (irq_lines),
        .irq_mask       (irq_mask),
        .cpu            (cpu),
        .data_out       (data_out),
        .out_reg        (out_reg),
        .routine_addr   (routine_addr),
        .irq_entry      (irq_entry),
        .in_irq_context (in_irq_context)
    );

    always #2 clk = ~clk;

    // Watchdog on the whole run
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("Timeout: run still busy after %0d cycles, errors %0d", cycle_count, errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic check_word(input string label, input cpu_isa_pkg::cpu_word_t exp,
                              input cpu_isa_pkg::cpu_word_t act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, label, exp, act);
        end
    endtask

    task automatic check_level_flag(input string label, input logic exp, input logic act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s %s: expected %b, actual %b", test_name, label, exp, act);
        end
    endtask

    task automatic check_reg(input string label, input cpu_isa_pkg::reg_id_t exp,
                             input cpu_isa_pkg::reg_id_t act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, label, exp, act);
        end
    endtask

    task automatic check_bit(input string label, input logic exp, input logic act);
        if (exp !== act)
        begin
            errors++;
            $display("FAIL %s %s: expected %b, actual %b", test_name, label, exp, act);
        end
    endtask

    function automatic cpu_isa_pkg::instr_t make_instr(input cpu_isa_pkg::opcode_t op,
                                                        input cpu_isa_pkg::arg_t arg);
        make_instr = {op, arg};
    endfunction

    // One CPU cycle, returns 1 time unit after the falling edge
    task automatic drive_cycle(input cpu_isa_pkg::instr_t instr, input irq_pkg::irq_vec_t lines,
                               input cpu_isa_pkg::cpu_word_t work,
                               input cpu_isa_pkg::cpu_word_t pc, input logic update);
        @(negedge clk);
        enable         = enable_sel;
        irq_mask       = mask_sel;
        irq_lines      = lines;
        cpu.instr      = instr;
        cpu.work_reg   = work;
        cpu.pc         = pc;
        cpu.cpu_update = update;
        #1;
    endtask

    task automatic test_reset_table();
        test_name = "reset_table";
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
        check_level_flag("in_irq_context", 1'b0, in_irq_context);
        check_bit("irq_entry", 1'b0, irq_entry);
        check_word("data_out", 16'h0, data_out);
        for (int a = 0; a < 4; a++)
        begin
            routine_exp[a] = cpu_isa_pkg::cpu_word_t'($urandom);
            drive_cycle(make_instr(cpu_isa_pkg::OPC_SETINT, a), 4'b0000, routine_exp[a],
                        16'h0, 1'b1);
        end
        for (int a = 0; a < 4; a++)
        begin
            drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINT, a), 4'b0000, 16'h0, 16'h0, 1'b0);
            // Registered read shows up in the following cycle
            drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
            check_word("getint", routine_exp[a], data_out);
        end
    endtask

    task automatic test_masking();
        test_name = "masking";
        mask_sel = 4'b1110;
        for (int i = 0; i < 4; i++)
        begin
            drive_cycle(NOP, 4'b0001, 16'h0, cpu_isa_pkg::cpu_word_t'($urandom), i[0]);
            check_bit("irq_entry", 1'b0, irq_entry);
            check_level_flag("in_irq_context", 1'b0, in_irq_context);
        end
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b1);
        check_level_flag("in_irq_context", 1'b0, in_irq_context);
    endtask

    task automatic test_external_entry();
        test_name = "external_entry";
        mask_sel = 4'b0100;
        saved_pc2 = cpu_isa_pkg::cpu_word_t'($urandom);
        drive_cycle(NOP, 4'b0100, 16'h0, 16'h0, 1'b0);
        // Latched pulse is visible one clock later
        drive_cycle(NOP, 4'b0000, 16'h0, saved_pc2, 1'b1);
        check_bit("irq_entry", 1'b1, irq_entry);
        check_word("routine_addr", routine_exp[2], routine_addr);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINTSTACK, 2), 4'b0000, 16'h0, 16'h0, 1'b0);
        check_level_flag("in_irq_context", 1'b1, in_irq_context);
        check_bit("irq_entry after update", 1'b0, irq_entry);
        check_word("saved pc", saved_pc2, data_out);
    endtask

    task automatic test_nesting();
        test_name = "nesting";
        mask_sel = 4'b1111;
        // Level 3 is below level 2 in priority
        drive_cycle(NOP, 4'b1000, 16'h0, 16'h0, 1'b0);
        drive_cycle(NOP, 4'b0000, 16'h0, cpu_isa_pkg::cpu_word_t'($urandom), 1'b1);
        check_bit("irq_entry level 3", 1'b0, irq_entry);
        check_word("routine_addr level 3", routine_exp[3], routine_addr);
        // Level 0 preempts
        pc_val = cpu_isa_pkg::cpu_word_t'($urandom);
        drive_cycle(NOP, 4'b0001, 16'h0, 16'h0, 1'b0);
        drive_cycle(NOP, 4'b0000, 16'h0, pc_val, 1'b1);
        check_bit("irq_entry level 0", 1'b1, irq_entry);
        check_word("routine_addr level 0", routine_exp[0], routine_addr);
        drive_cycle(cpu_isa_pkg::INST_RETINT, 4'b0000, 16'h0, 16'h0, 1'b1);
        check_level_flag("in_irq_context", 1'b1, in_irq_context);
        check_word("retint to level 2", pc_val, data_out);
        check_reg("out_reg", cpu_isa_pkg::REG_PC, out_reg);
        drive_cycle(cpu_isa_pkg::INST_RETINT, 4'b0000, 16'h0, 16'h0, 1'b1);
        check_level_flag("in_irq_context at level 2", 1'b1, in_irq_context);
        check_word("retint to normal", saved_pc2, data_out);
        check_reg("out_reg", cpu_isa_pkg::REG_PC, out_reg);
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
        check_level_flag("in_irq_context after return", 1'b0, in_irq_context);
        check_reg("out_reg idle", cpu_isa_pkg::reg_id_t'(0), out_reg);
    endtask

    task automatic test_softint();
        test_name = "softint";
        pc_val = cpu_isa_pkg::cpu_word_t'($urandom);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_SOFTINT, 1), 4'b0000, 16'h0, pc_val, 1'b0);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_SOFTINT, 1), 4'b0000, 16'h0, pc_val, 1'b1);
        check_bit("irq_entry", 1'b1, irq_entry);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINTSTACK, 1), 4'b0000, 16'h0, 16'h0, 1'b0);
        check_level_flag("in_irq_context", 1'b1, in_irq_context);
        check_word("saved pc plus one", pc_val + 16'd1, data_out);
        // Leave level 1 so the last test starts from the normal context
        drive_cycle(cpu_isa_pkg::INST_RETINT, 4'b0000, 16'h0, 16'h0, 1'b1);
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
        check_level_flag("in_irq_context after return", 1'b0, in_irq_context);
        check_bit("irq_entry after return", 1'b0, irq_entry);
    endtask

    task automatic test_stack_enable();
        test_name = "stack_enable";
        word_val = cpu_isa_pkg::cpu_word_t'($urandom);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_SETINTSTACK, 3), 4'b0000, word_val, 16'h0, 1'b0);
        check_word("setintstack echo", word_val, data_out);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINTSTACK, 3), 4'b0000, 16'h0, 16'h0, 1'b0);
        check_word("getintstack", word_val, data_out);
        // Frozen block ignores requests, updates and writes
        enable_sel = 1'b0;
        drive_cycle(NOP, 4'b0001, 16'h0, 16'h0, 1'b0);
        drive_cycle(NOP, 4'b0001, 16'h0, 16'h0, 1'b1);
        check_bit("irq_entry disabled", 1'b0, irq_entry);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_SETINT, 0), 4'b0000, ~routine_exp[0], 16'h0, 1'b1);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_SETINTSTACK, 3), 4'b0000, ~word_val, 16'h0, 1'b1);
        check_level_flag("in_irq_context disabled", 1'b0, in_irq_context);
        enable_sel = 1'b1;
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
        check_bit("irq_entry enabled", 1'b0, irq_entry);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINT, 0), 4'b0000, 16'h0, 16'h0, 1'b0);
        drive_cycle(NOP, 4'b0000, 16'h0, 16'h0, 1'b0);
        check_word("routine kept", routine_exp[0], data_out);
        drive_cycle(make_instr(cpu_isa_pkg::OPC_GETINTSTACK, 3), 4'b0000, 16'h0, 16'h0, 1'b0);
        check_word("stack word kept", word_val, data_out);
    endtask

    initial
    begin
        errors      = 0;
        cycle_count = 0;
        void'($urandom(78));
        clk         = 1'b0;
        reset       = 1'b0;
        enable      = 1'b0;
        enable_sel  = 1'b1;
        mask_sel    = 4'b0000;
        irq_lines   = '0;
        irq_mask    = '0;
        cpu         = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        test_reset_table();
        test_masking();
        test_external_entry();
        test_nesting();
        test_softint();
        test_stack_enable();
        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
logic/cpu_isa_pkg.sv
logic/irq_pkg.sv
logic/irq_request_capture.sv
logic/irq_context_stack.sv
logic/irq_vector_table.sv
logic/irq_controller_top.sv
verif/irq_controller_tb.sv
